/* hw/hyperbus_rd_pkg.sv */
/*
 * HyperBus read path shared definitions.
 * Word and lane widths, transfer size codes and command field types.
 */
package hyperbus_rd_pkg;

  // A PHY word and an AXI beat have the same width.
  localparam int unsigned PhyWidth = 32;
  localparam int unsigned NumLanes = PhyWidth / 8;

  // Transfer size code, as on the AXI AxSIZE field.
  typedef logic [2:0] size_t;

  localparam size_t SizeByte = 3'd0;  // One byte per beat.
  localparam size_t SizeHalf = 3'd1;  // Two bytes per beat.
  localparam size_t SizeWord = 3'd2;  // Four bytes per beat.

  // Byte offset within a word.
  typedef logic [$clog2(NumLanes)-1:0] offs_t;

  // Beat count minus one.
  typedef logic [7:0] len_t;

  // One PHY word as it sits in the word FIFO.
  typedef struct packed {
    logic [PhyWidth-1:0] data;
    logic                last;
  } phy_word_t;

endpackage

/* hw/hyperbus_word_fifo.sv */
/*
 * Word FIFO for the HyperBus read path.
 * Circular buffer for an arbitrary payload type with a registered push ready.
 * FifoDepth must be a power of two and at least two.
 */
`timescale 1ns/100ps

module hyperbus_word_fifo #(
  parameter int unsigned FifoDepth = 4,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_i
);

  localparam int unsigned PtrWidth = $clog2(FifoDepth);

  // The top pointer bit tells a full buffer from an empty one.
  logic [PtrWidth:0] wr_ptr_q, wr_ptr_d;
  logic [PtrWidth:0] rd_ptr_q, rd_ptr_d;
  logic              push_ready_q;
  logic              push;
  logic              full_d;

  payload_t mem_q [FifoDepth];

  assign push = push_valid_i && push_ready_q;

  assign wr_ptr_d = wr_ptr_q + (PtrWidth + 1)'(push);
  assign rd_ptr_d = rd_ptr_q + (PtrWidth + 1)'(pop_i);

  // Full in the next cycle, so ready can come straight from a flop.
  assign full_d = (wr_ptr_d[PtrWidth] != rd_ptr_d[PtrWidth]) &&
                  (wr_ptr_d[PtrWidth-1:0] == rd_ptr_d[PtrWidth-1:0]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      push_ready_q <= 1'b0;  // Held off until the first cycle out of reset.
    end else begin
      wr_ptr_q     <= wr_ptr_d;
      rd_ptr_q     <= rd_ptr_d;
      push_ready_q <= !full_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q[PtrWidth-1:0]] <= push_data_i;
    end
  end

  assign push_ready_o = push_ready_q;
  assign pop_valid_o  = (wr_ptr_q != rd_ptr_q);
  assign pop_data_o   = mem_q[rd_ptr_q[PtrWidth-1:0]];

  // The reader may only take a word that is already stored.
  no_pop_when_empty : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> pop_valid_o)
    else $error("Word FIFO popped while empty.");

endmodule

/* hw/hyperbus_burst_tracker.sv */
/*
 * Burst tracker for the HyperBus read path.
 * Latches the read command and counts the beats still owed to the AXI side.
 */
`timescale 1ns/100ps

module hyperbus_burst_tracker
  import hyperbus_rd_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  cmd_valid_i,
  input  offs_t cmd_addr_i,
  input  len_t  cmd_len_i,
  input  size_t cmd_size_i,
  input  logic  beat_fire_i,
  output logic  active_o,
  output size_t size_o,
  output offs_t start_offs_o,
  output logic  final_beat_o
);

  logic  active_q, active_d;
  size_t size_q, size_d;
  offs_t offs_q, offs_d;
  len_t  remaining_q, remaining_d;  // Beats still owed, minus one.
  logic  final_beat;

  assign final_beat = active_q && (remaining_q == '0);

  always_comb begin
    active_d    = active_q;
    size_d      = size_q;
    offs_d      = offs_q;
    remaining_d = remaining_q;

    if (cmd_valid_i) begin
      active_d    = 1'b1;
      size_d      = cmd_size_i;
      remaining_d = cmd_len_i;
      // Full-word bursts start at lane zero, whatever the address says.
      if (cmd_size_i >= SizeWord) begin
        offs_d = '0;
      end else begin
        offs_d = cmd_addr_i;
      end
    end else if (beat_fire_i) begin
      if (final_beat) begin
        active_d = 1'b0;
      end else begin
        remaining_d = remaining_q - len_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q    <= 1'b0;
      size_q      <= SizeByte;
      offs_q      <= '0;
      remaining_q <= '0;
    end else begin
      active_q    <= active_d;
      size_q      <= size_d;
      offs_q      <= offs_d;
      remaining_q <= remaining_d;
    end
  end

  assign active_o     = active_q;
  assign size_o       = size_q;
  assign start_offs_o = offs_q;
  assign final_beat_o = final_beat;

  // Only one burst may be in flight.
  cmd_while_idle : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_i |-> !active_q)
    else $error("Read command arrived while a burst is still active.");

  // Bursts wider than the PHY word are not supported.
  size_supported : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_i |-> (cmd_size_i <= SizeWord))
    else $error("Read command size above one word.");

endmodule

/* hw/hyperbus_splitter.sv */
/*
 * Beat splitter for the HyperBus read path.
 * Walks the byte offset through each PHY word, issues one beat per transfer
 * size and pops a word once the burst has left it.
 */
`timescale 1ns/100ps

module hyperbus_splitter
  import hyperbus_rd_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  // Word FIFO head.
  input  logic                word_valid_i,
  input  phy_word_t           word_i,
  output logic                word_pop_o,
  // Burst state from the tracker.
  input  logic                active_i,
  input  size_t               size_i,
  input  offs_t               start_offs_i,
  input  logic                final_beat_i,
  // Beats towards the lane mask.
  input  logic                beat_ready_i,
  output logic                beat_valid_o,
  output logic [PhyWidth-1:0] beat_data_o,
  output offs_t               beat_offs_o,
  output logic                beat_last_o,
  output logic                beat_fire_o
);

  offs_t       offs_q, offs_d;
  logic        loaded_q, loaded_d;  // Offset holds a value of the current burst.
  logic        drain_q, drain_d;
  offs_t       cur_offs;
  logic [2:0]  step;
  logic [2:0]  next_offs;
  logic        wrap;
  logic        beat_fire;

  // The first beat of a burst takes its offset straight from the tracker.
  assign cur_offs = loaded_q ? offs_q : start_offs_i;

  assign step      = 3'd1 << size_i;
  assign next_offs = {1'b0, cur_offs} + step;
  assign wrap      = next_offs[2];  // Next beat starts in the next word.

  // Surplus words of the previous burst must be gone before new beats go out.
  assign beat_valid_o = active_i && word_valid_i && !drain_q;
  assign beat_fire    = beat_valid_o && beat_ready_i;

  always_comb begin
    offs_d     = offs_q;
    loaded_d   = loaded_q;
    drain_d    = drain_q;
    word_pop_o = 1'b0;

    if (drain_q) begin
      // Drop leftover words up to the one that closes the PHY burst.
      if (word_valid_i) begin
        word_pop_o = 1'b1;
        if (word_i.last) begin
          drain_d = 1'b0;
        end
      end
    end else if (beat_fire) begin
      if (final_beat_i) begin
        word_pop_o = 1'b1;
        loaded_d   = 1'b0;
        offs_d     = '0;
        drain_d    = !word_i.last;
      end else begin
        word_pop_o = wrap;
        loaded_d   = 1'b1;
        offs_d     = next_offs[1:0];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offs_q   <= '0;
      loaded_q <= 1'b0;
      drain_q  <= 1'b0;
    end else begin
      offs_q   <= offs_d;
      loaded_q <= loaded_d;
      drain_q  <= drain_d;
    end
  end

  assign beat_data_o = word_i.data;
  assign beat_offs_o = cur_offs;
  assign beat_last_o = final_beat_i;
  assign beat_fire_o = beat_fire;

  // A stalled beat stays put until the lane mask takes it.
  beat_held_on_stall : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (beat_valid_o && !beat_ready_i) |=>
      (beat_valid_o && $stable(beat_data_o) && $stable(beat_offs_o)))
    else $error("Splitter beat changed while stalled.");

  // A burst never outruns the PHY stream that belongs to it.
  no_beat_past_word_last : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (beat_fire && word_i.last && !final_beat_i && wrap) |-> 1'b0)
    else $error("PHY burst ended before the read burst.");

endmodule

/* hw/hyperbus_lane_mask.sv */
/*
 * Lane mask and output stage of the HyperBus read path.
 * Zeroes unused byte lanes and registers the AXI read beat.
 */
`timescale 1ns/100ps

module hyperbus_lane_mask
  import hyperbus_rd_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                beat_valid_i,
  input  logic [PhyWidth-1:0] beat_data_i,
  input  offs_t               beat_offs_i,
  input  logic                beat_last_i,
  input  size_t               size_i,
  output logic                beat_ready_o,
  output logic                r_valid_o,
  output logic [PhyWidth-1:0] r_data_o,
  output logic                r_last_o,
  input  logic                r_ready_i
);

  logic [2:0]          lane_lo, lane_hi;
  logic [PhyWidth-1:0] masked_data;
  logic                r_valid_q;
  logic [PhyWidth-1:0] r_data_q;
  logic                r_last_q;

  assign lane_lo = {1'b0, beat_offs_i};
  assign lane_hi = lane_lo + (3'd1 << size_i);

  always_comb begin
    for (int i = 0; i < NumLanes; i++) begin
      if ((3'(i) >= lane_lo) && (3'(i) < lane_hi)) begin
        masked_data[8*i +: 8] = beat_data_i[8*i +: 8];
      end else begin
        masked_data[8*i +: 8] = 8'h00;
      end
    end
  end

  // Room when empty, or when the current beat leaves this cycle.
  assign beat_ready_o = !r_valid_q || r_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else if (beat_ready_o) begin
      r_valid_q <= beat_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_valid_i && beat_ready_o) begin
      r_data_q <= masked_data;
      r_last_q <= beat_last_i;
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;
  assign r_last_o  = r_last_q;

endmodule

/* hw/hyperbus_rd_top.sv */
/*
 * HyperBus read data path.
 * PHY words pass a FIFO and a splitter that cuts them into AXI read beats.
 */
`timescale 1ns/100ps

module hyperbus_rd_top
  import hyperbus_rd_pkg::*;
#(
  parameter int unsigned FifoDepth = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Read command.
  input  logic                cmd_valid_i,
  input  offs_t               cmd_addr_i,
  input  len_t                cmd_len_i,
  input  size_t               cmd_size_i,
  // PHY word stream.
  input  logic                phy_valid_i,
  input  logic [PhyWidth-1:0] phy_data_i,
  input  logic                phy_last_i,
  output logic                phy_ready_o,
  // AXI read data.
  output logic                r_valid_o,
  output logic [PhyWidth-1:0] r_data_o,
  output logic                r_last_o,
  input  logic                r_ready_i
);

  logic                word_valid, word_pop;
  phy_word_t           word;
  logic                active, final_beat, beat_fire;
  size_t               size;
  offs_t               start_offs;
  logic                beat_valid, beat_ready, beat_last;
  logic [PhyWidth-1:0] beat_data;
  offs_t               beat_offs;

  hyperbus_word_fifo #(
    .FifoDepth (FifoDepth),
    .payload_t (phy_word_t)
  ) hyperbus_word_fifo_i (
    .clk_i, .rst_ni,
    .push_valid_i (phy_valid_i),
    .push_data_i  ({phy_data_i, phy_last_i}),
    .push_ready_o (phy_ready_o),
    .pop_valid_o  (word_valid),
    .pop_data_o   (word),
    .pop_i        (word_pop)
  );

  hyperbus_burst_tracker hyperbus_burst_tracker_i (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_addr_i, .cmd_len_i, .cmd_size_i,
    .beat_fire_i (beat_fire), .active_o (active), .size_o (size),
    .start_offs_o (start_offs), .final_beat_o (final_beat)
  );

  hyperbus_splitter hyperbus_splitter_i (
    .clk_i, .rst_ni, .word_valid_i (word_valid), .word_i (word), .word_pop_o (word_pop),
    .active_i (active), .size_i (size), .start_offs_i (start_offs),
    .final_beat_i (final_beat), .beat_ready_i (beat_ready), .beat_valid_o (beat_valid),
    .beat_data_o (beat_data), .beat_offs_o (beat_offs), .beat_last_o (beat_last),
    .beat_fire_o (beat_fire)
  );

  hyperbus_lane_mask hyperbus_lane_mask_i (
    .clk_i, .rst_ni, .beat_valid_i (beat_valid), .beat_data_i (beat_data),
    .beat_offs_i (beat_offs), .beat_last_i (beat_last), .size_i (size),
    .beat_ready_o (beat_ready), .r_valid_o, .r_data_o, .r_last_o, .r_ready_i
  );

endmodule

/* verif/hyperbus_rd_tb.sv */
/*
 * Testbench for the HyperBus read data path.
 * Runs a table of read bursts and checks each beat against a reference model.
 */
`timescale 1ns/100ps

module hyperbus_rd_tb
  import hyperbus_rd_pkg::*;
();

  localparam int NumRows  = 12;
  localparam int MaxWords = 16;
  localparam int MaxBeats = 32;
  localparam int Timeout  = 500;  // Cycles allowed for one burst.

  typedef struct {
    string       name;
    offs_t       addr;
    len_t        len;
    size_t       size;
    int unsigned num_words;  // Words needed plus surplus.
  } burst_t;

  logic                clk_i, rst_ni;
  logic                cmd_valid_i;
  offs_t               cmd_addr_i;
  len_t                cmd_len_i;
  size_t               cmd_size_i;
  logic                phy_valid_i, phy_last_i, phy_ready_o;
  logic [PhyWidth-1:0] phy_data_i;
  logic                r_valid_o, r_last_o, r_ready_i;
  logic [PhyWidth-1:0] r_data_o;

  burst_t              rows [NumRows];
  logic [PhyWidth-1:0] words [MaxWords];
  logic [PhyWidth-1:0] exp_data [MaxBeats];
  logic [31:0]         rand_state;
  int unsigned         num_checks, num_errors, num_bursts;
  logic                timed_out;

  hyperbus_rd_top #(.FifoDepth(4)) hyperbus_rd_top_i (.*);

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Keeps count bytes starting at lane first, all other lanes read as zero.
  function automatic logic [PhyWidth-1:0] keep_lanes(logic [PhyWidth-1:0] data,
                                                     int unsigned first, int unsigned count);
    logic [PhyWidth-1:0] result;
    result = '0;
    for (int unsigned b = first; b < first + count; b++) begin
      result[8*b +: 8] = data[8*b +: 8];
    end
    return result;
  endfunction

  task automatic compare_value(string what, logic [PhyWidth-1:0] expected,
                               logic [PhyWidth-1:0] actual);
    num_checks++;
    if (expected !== actual) begin
      num_errors++;
      $display("MISMATCH %s: expected %h, actual %h", what, expected, actual);
    end
  endtask

  task automatic fill_table();
    rows[0]  = '{"word_aligned",    2'd0, 8'd3,  SizeWord, 4};
    rows[1]  = '{"word_misaligned", 2'd2, 8'd2,  SizeWord, 3};
    rows[2]  = '{"byte_offs0",      2'd0, 8'd5,  SizeByte, 2};
    rows[3]  = '{"byte_offs1",      2'd1, 8'd3,  SizeByte, 2};
    rows[4]  = '{"byte_offs2",      2'd2, 8'd1,  SizeByte, 1};
    rows[5]  = '{"byte_offs3",      2'd3, 8'd6,  SizeByte, 3};
    rows[6]  = '{"half_offs0",      2'd0, 8'd4,  SizeHalf, 3};
    rows[7]  = '{"half_offs2",      2'd2, 8'd5,  SizeHalf, 4};
    rows[8]  = '{"surplus_word",    2'd0, 8'd1,  SizeWord, 4};  // Two words too many.
    rows[9]  = '{"surplus_byte",    2'd1, 8'd1,  SizeByte, 3};
    rows[10] = '{"after_surplus",   2'd0, 8'd2,  SizeHalf, 2};
    rows[11] = '{"long_half",       2'd2, 8'd15, SizeHalf, 9};
  endtask

  // Draws the PHY words and works out the beats the burst must produce.
  task automatic prepare_burst(input burst_t row);
    int unsigned bytes;
    int unsigned offs;
    int unsigned w;
    bytes = 1 << row.size;
    offs  = (row.size == SizeWord) ? 0 : 32'(row.addr);
    w     = 0;
    for (int unsigned k = 0; k < row.num_words; k++) begin
      words[k] = next_rand();
    end
    for (int unsigned i = 0; i < 32'(row.len) + 1; i++) begin
      exp_data[i] = keep_lanes(words[w], offs, bytes);
      offs += bytes;
      if (offs >= NumLanes) begin  // Burst moves on to the next PHY word.
        offs -= NumLanes;
        w++;
      end
    end
  endtask

  task automatic run_burst(input burst_t row);
    int unsigned num_beats, sent, got, phy_wait, r_wait, errors_before;
    logic [31:0] rnd;
    num_beats     = 32'(row.len) + 1;
    errors_before = num_errors;
    prepare_burst(row);
    @(negedge clk_i);
    cmd_valid_i = 1'b1;
    cmd_addr_i  = row.addr;
    cmd_len_i   = row.len;
    cmd_size_i  = row.size;
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    fork
      begin
        sent     = 0;
        phy_wait = 0;
        while (sent < row.num_words && phy_wait < Timeout) begin
          @(negedge clk_i);
          phy_valid_i = 1'b1;
          phy_data_i  = words[sent];
          phy_last_i  = (sent == row.num_words - 1);
          if (phy_ready_o) sent++;  // Taken at the coming rising edge.
          phy_wait++;
        end
        @(negedge clk_i);
        phy_valid_i = 1'b0;
        phy_last_i  = 1'b0;
        if (sent < row.num_words) begin
          $display("Timed out in %s: the PHY stream stopped taking words at word %0d.",
                   row.name, sent);
          timed_out = 1'b1;
        end
      end
      begin
        got    = 0;
        r_wait = 0;
        while (got < num_beats && r_wait < Timeout) begin
          @(negedge clk_i);
          rnd       = next_rand();
          r_ready_i = rnd[16];
          if (r_valid_o && r_ready_i) begin
            compare_value($sformatf("%s beat %0d data", row.name, got),
                          exp_data[got], r_data_o);
            compare_value($sformatf("%s beat %0d last", row.name, got),
                          PhyWidth'(got == num_beats - 1), PhyWidth'(r_last_o));
            got++;
          end
          r_wait++;
        end
        @(negedge clk_i);
        r_ready_i = 1'b0;  // A stray extra beat shows up in the next burst.
        if (got < num_beats) begin
          $display("Timed out in %s: only %0d of %0d read beats arrived.",
                   row.name, got, num_beats);
          timed_out = 1'b1;
        end
      end
    join
    num_bursts++;
    $display("%s: %0d beats from %0d words, %0d errors", row.name, got, sent,
             num_errors - errors_before);
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_addr_i  = '0;
    cmd_len_i   = '0;
    cmd_size_i  = SizeByte;
    phy_valid_i = 1'b0;
    phy_data_i  = '0;
    phy_last_i  = 1'b0;
    r_ready_i   = 1'b0;
    rand_state  = 32'h60cf299e;
    num_checks  = 0;
    num_errors  = 0;
    num_bursts  = 0;
    timed_out   = 1'b0;
    fill_table();
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int r = 0; r < NumRows && !timed_out; r++) begin
      run_burst(rows[r]);
    end
    repeat (4) @(negedge clk_i);
    $display("Bursts: %0d, checks: %0d, errors: %0d", num_bursts, num_checks, num_errors);
    if (num_errors == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* hyperbus_rd.f */
hw/hyperbus_rd_pkg.sv
hw/hyperbus_word_fifo.sv
hw/hyperbus_burst_tracker.sv
hw/hyperbus_splitter.sv
hw/hyperbus_lane_mask.sv
hw/hyperbus_rd_top.sv
verif/hyperbus_rd_tb.sv

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= hyperbus_rd_tb
FILELIST ?= hyperbus_rd.f
BUILD    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD)
